//--- bram/bram.sv
`timescale 1ns/100ps
`default_nettype none

module bram (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        valid_i,
  input  wire logic [31:0] addr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  wstrb_i,
  output logic      [31:0] rdata_o,
  output logic             ready_o
);

  logic [31:0] mem [0:soc_pkg::bram_depth-1];
  logic [9:0]  word_idx;
  logic        access;

  assign word_idx = addr_i[11:2];
  assign access   = valid_i && !ready_o; // The ready cycle is not a new request

  always_ff @(posedge clk) begin
    if (access) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[word_idx]; // Old word on a write
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= access;
    end
  end

endmodule

`default_nettype wire

//--- clint/clint.sv
`timescale 1ns/100ps
`default_nettype none

module clint (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        valid_i,
  input  wire logic [31:0] addr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  wstrb_i,
  output logic      [31:0] rdata_o,
  output logic             ready_o,
  output logic             msip_o,
  output logic             mtip_o
);

  logic [63:0] mtime_r;
  logic [63:0] mtimecmp_r;
  logic        msip_r;
  logic        access;
  logic        write;

  assign access = valid_i && !ready_o;
  assign write  = access && (wstrb_i != 4'b0000);
  assign msip_o = msip_r;

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime_r    <= 64'h0;
      mtimecmp_r <= '1; // No timer interrupt until software sets a compare value
      msip_r     <= 1'b0;
      mtip_o     <= 1'b0;
      ready_o    <= 1'b0;
    end else begin
      mtime_r <= mtime_r + 64'd1;
      mtip_o  <= (mtime_r >= mtimecmp_r);
      ready_o <= access;
      if (write) begin
        case (addr_i)
          soc_pkg::clint_msip_offset:             msip_r <= wdata_i[0];
          soc_pkg::clint_mtimecmp_offset:         mtimecmp_r[31:0] <= wdata_i;
          soc_pkg::clint_mtimecmp_offset + 32'd4: mtimecmp_r[63:32] <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (addr_i)
        soc_pkg::clint_msip_offset:             rdata_o <= {31'h0, msip_r};
        soc_pkg::clint_mtimecmp_offset:         rdata_o <= mtimecmp_r[31:0];
        soc_pkg::clint_mtimecmp_offset + 32'd4: rdata_o <= mtimecmp_r[63:32];
        soc_pkg::clint_mtime_offset:            rdata_o <= mtime_r[31:0];
        soc_pkg::clint_mtime_offset + 32'd4:    rdata_o <= mtime_r[63:32];
        default:                                rdata_o <= 32'h0;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- common/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // Address windows with an exclusive top address
  localparam logic [31:0] bram_base_addr  = 32'h0000_0000;
  localparam logic [31:0] bram_top_addr   = 32'h0000_1000;
  localparam logic [31:0] clint_base_addr = 32'h0200_0000;
  localparam logic [31:0] clint_top_addr  = 32'h0200_C000;
  localparam logic [31:0] uart_base_addr  = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr   = 32'h1000_0010;

  localparam int bram_depth = 1024; // Depth in words indexed by addr[11:2]

  // CLINT register offsets with the high halves at +4
  localparam logic [31:0] clint_msip_offset     = 32'h0000_0000;
  localparam logic [31:0] clint_mtimecmp_offset = 32'h0000_4000;
  localparam logic [31:0] clint_mtime_offset    = 32'h0000_BFF8;

  // UART registers
  localparam logic [31:0] uart_data_offset   = 32'h0000_0000;
  localparam logic [31:0] uart_status_offset = 32'h0000_0004; // Bit 0 is busy

  localparam int uart_clks_per_bit = 4; // Kept short for simulation

endpackage

`default_nettype wire

//--- rtl/bus_router.sv
`timescale 1ns/100ps
`default_nettype none

module bus_router (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        inst_valid_i,
  input  wire logic [31:0] inst_addr_i,
  input  wire logic [31:0] inst_wdata_i,
  input  wire logic [3:0]  inst_wstrb_i,
  output logic      [31:0] inst_rdata_o,
  output logic             inst_ready_o,
  input  wire logic        data_valid_i,
  input  wire logic [31:0] data_addr_i,
  input  wire logic [31:0] data_wdata_i,
  input  wire logic [3:0]  data_wstrb_i,
  output logic      [31:0] data_rdata_o,
  output logic             data_ready_o,
  output logic             bram_valid_o,
  output logic      [31:0] bram_addr_o,
  output logic      [31:0] bram_wdata_o,
  output logic      [3:0]  bram_wstrb_o,
  input  wire logic [31:0] bram_rdata_i,
  input  wire logic        bram_ready_i,
  output logic             clint_valid_o,
  output logic      [31:0] clint_addr_o,
  output logic      [31:0] clint_wdata_o,
  output logic      [3:0]  clint_wstrb_o,
  input  wire logic [31:0] clint_rdata_i,
  input  wire logic        clint_ready_i,
  output logic             uart_valid_o,
  output logic      [31:0] uart_addr_o,
  output logic      [31:0] uart_wdata_o,
  output logic      [3:0]  uart_wstrb_o,
  input  wire logic [31:0] uart_rdata_i,
  input  wire logic        uart_ready_i
);

  // Select bit 0 is the CLINT, bit 1 the UART and bit 2 the BRAM
  logic [2:0]  inst_hit;
  logic [2:0]  data_hit;
  logic [2:0]  inst_sel;
  logic [2:0]  data_sel;
  logic [2:0]  slv_ready;
  logic [2:0]  inst_own_r;
  logic [2:0]  data_own_r;
  logic [31:0] inst_off;
  logic [31:0] data_off;

  function automatic logic [2:0] decode_hit(input logic [31:0] addr);
    logic [2:0] hit;
    hit = 3'b000;
    if (addr >= soc_pkg::clint_base_addr && addr < soc_pkg::clint_top_addr) begin
      hit = 3'b001;
    end else if (addr >= soc_pkg::uart_base_addr && addr < soc_pkg::uart_top_addr) begin
      hit = 3'b010;
    end else if (addr >= soc_pkg::bram_base_addr && addr < soc_pkg::bram_top_addr) begin
      hit = 3'b100;
    end
    return hit;
  endfunction

  function automatic logic [31:0] base_of(input logic [2:0] hit);
    logic [31:0] base;
    case (hit)
      3'b001:  base = soc_pkg::clint_base_addr;
      3'b010:  base = soc_pkg::uart_base_addr;
      3'b100:  base = soc_pkg::bram_base_addr;
      default: base = 32'h0;
    endcase
    return base;
  endfunction

  assign inst_hit = decode_hit(inst_addr_i);
  assign data_hit = decode_hit(data_addr_i);
  assign inst_off = inst_addr_i - base_of(inst_hit);
  assign data_off = data_addr_i - base_of(data_hit);

  assign data_sel = data_valid_i ? data_hit : 3'b000;
  assign inst_sel = inst_valid_i ? (inst_hit & ~data_sel) : 3'b000; // Data port wins a collision

  assign clint_valid_o = data_sel[0] | inst_sel[0];
  assign clint_addr_o  = data_sel[0] ? data_off : inst_off;
  assign clint_wdata_o = data_sel[0] ? data_wdata_i : inst_wdata_i;
  assign clint_wstrb_o = data_sel[0] ? data_wstrb_i : inst_wstrb_i;

  assign uart_valid_o = data_sel[1] | inst_sel[1];
  assign uart_addr_o  = data_sel[1] ? data_off : inst_off;
  assign uart_wdata_o = data_sel[1] ? data_wdata_i : inst_wdata_i;
  assign uart_wstrb_o = data_sel[1] ? data_wstrb_i : inst_wstrb_i;

  assign bram_valid_o = data_sel[2] | inst_sel[2];
  assign bram_addr_o  = data_sel[2] ? data_off : inst_off;
  assign bram_wdata_o = data_sel[2] ? data_wdata_i : inst_wdata_i;
  assign bram_wstrb_o = data_sel[2] ? data_wstrb_i : inst_wstrb_i;

  assign slv_ready = {bram_ready_i, uart_ready_i, clint_ready_i};

  // Owner flags steer the response of each slave back to its master
  always_ff @(posedge clk) begin
    if (!rst) begin
      inst_own_r <= 3'b000;
      data_own_r <= 3'b000;
    end else begin
      inst_own_r <= inst_sel & ~slv_ready;
      data_own_r <= data_sel & ~slv_ready;
    end
  end

  always_comb begin
    inst_rdata_o = 32'h0;
    inst_ready_o = 1'b0;
    if (inst_own_r[0] && clint_ready_i) begin
      inst_rdata_o = clint_rdata_i;
      inst_ready_o = 1'b1;
    end else if (inst_own_r[1] && uart_ready_i) begin
      inst_rdata_o = uart_rdata_i;
      inst_ready_o = 1'b1;
    end else if (inst_own_r[2] && bram_ready_i) begin
      inst_rdata_o = bram_rdata_i;
      inst_ready_o = 1'b1;
    end
  end

  always_comb begin
    data_rdata_o = 32'h0;
    data_ready_o = 1'b0;
    if (data_own_r[0] && clint_ready_i) begin
      data_rdata_o = clint_rdata_i;
      data_ready_o = 1'b1;
    end else if (data_own_r[1] && uart_ready_i) begin
      data_rdata_o = uart_rdata_i;
      data_ready_o = 1'b1;
    end else if (data_own_r[2] && bram_ready_i) begin
      data_rdata_o = bram_rdata_i;
      data_ready_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/soc_bus.sv
`timescale 1ns/100ps
`default_nettype none

module soc_bus (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        inst_valid_i,
  input  wire logic [31:0] inst_addr_i,
  input  wire logic [31:0] inst_wdata_i,
  input  wire logic [3:0]  inst_wstrb_i,
  output logic      [31:0] inst_rdata_o,
  output logic             inst_ready_o,
  input  wire logic        data_valid_i,
  input  wire logic [31:0] data_addr_i,
  input  wire logic [31:0] data_wdata_i,
  input  wire logic [3:0]  data_wstrb_i,
  output logic      [31:0] data_rdata_o,
  output logic             data_ready_o,
  output logic             tx_o,
  output logic             msip_o,
  output logic             mtip_o
);

  logic        bram_valid;
  logic [31:0] bram_addr;
  logic [31:0] bram_wdata;
  logic [3:0]  bram_wstrb;
  logic [31:0] bram_rdata;
  logic        bram_ready;

  logic        clint_valid;
  logic [31:0] clint_addr;
  logic [31:0] clint_wdata;
  logic [3:0]  clint_wstrb;
  logic [31:0] clint_rdata;
  logic        clint_ready;

  logic        uart_valid;
  logic [31:0] uart_addr;
  logic [31:0] uart_wdata;
  logic [3:0]  uart_wstrb;
  logic [31:0] uart_rdata;
  logic        uart_ready;

  bus_router bus_router_inst (
    .clk           (clk),
    .rst           (rst),
    .inst_valid_i  (inst_valid_i),
    .inst_addr_i   (inst_addr_i),
    .inst_wdata_i  (inst_wdata_i),
    .inst_wstrb_i  (inst_wstrb_i),
    .inst_rdata_o  (inst_rdata_o),
    .inst_ready_o  (inst_ready_o),
    .data_valid_i  (data_valid_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_wstrb_i  (data_wstrb_i),
    .data_rdata_o  (data_rdata_o),
    .data_ready_o  (data_ready_o),
    .bram_valid_o  (bram_valid),
    .bram_addr_o   (bram_addr),
    .bram_wdata_o  (bram_wdata),
    .bram_wstrb_o  (bram_wstrb),
    .bram_rdata_i  (bram_rdata),
    .bram_ready_i  (bram_ready),
    .clint_valid_o (clint_valid),
    .clint_addr_o  (clint_addr),
    .clint_wdata_o (clint_wdata),
    .clint_wstrb_o (clint_wstrb),
    .clint_rdata_i (clint_rdata),
    .clint_ready_i (clint_ready),
    .uart_valid_o  (uart_valid),
    .uart_addr_o   (uart_addr),
    .uart_wdata_o  (uart_wdata),
    .uart_wstrb_o  (uart_wstrb),
    .uart_rdata_i  (uart_rdata),
    .uart_ready_i  (uart_ready)
  );

  bram bram_inst (
    .clk     (clk),
    .rst     (rst),
    .valid_i (bram_valid),
    .addr_i  (bram_addr),
    .wdata_i (bram_wdata),
    .wstrb_i (bram_wstrb),
    .rdata_o (bram_rdata),
    .ready_o (bram_ready)
  );

  clint clint_inst (
    .clk     (clk),
    .rst     (rst),
    .valid_i (clint_valid),
    .addr_i  (clint_addr),
    .wdata_i (clint_wdata),
    .wstrb_i (clint_wstrb),
    .rdata_o (clint_rdata),
    .ready_o (clint_ready),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o)
  );

  uart uart_inst (
    .clk     (clk),
    .rst     (rst),
    .valid_i (uart_valid),
    .addr_i  (uart_addr),
    .wdata_i (uart_wdata),
    .wstrb_i (uart_wstrb),
    .rdata_o (uart_rdata),
    .ready_o (uart_ready),
    .tx_o    (tx_o)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/soc_bus_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1

//--- soc_bus.f
common/soc_pkg.sv
rtl/bus_router.sv
bram/bram.sv
clint/clint.sv
uart/uart.sv
rtl/soc_bus.sv
testbench/soc_bus_tb.sv

//--- testbench/soc_bus_stimulus.txt
# op port addr wdata wstrb expected, all hex; port I is instruction, D is data
# BRAM reads are checked against the testbench memory model, their expected is 0
W D 00000040 deadbeef f 00000000
R D 00000040 00000000 0 00000000
W D 00000040 00005a00 2 00000000
R D 00000040 00000000 0 00000000
R I 00000040 00000000 0 00000000
R I 00000204 00000000 0 00000000
R D 0000020c 00000000 0 00000000
P D 00000080 12345678 f 00000000
R D 00000080 00000000 0 00000000
U D 10000000 00000041 1 00000041
U D 10000000 000000a5 1 000000a5
R D 10000004 00000000 0 00000001
W D 02000000 00000001 f 00000001
W D 02000000 00000000 f 00000000
T D 02000000 00000028 0 00000001
N D 20000000 00000000 0 00000000
R D 00000040 00000000 0 00000000
W I 00000300 cafef00d f 00000000
R D 00000300 00000000 0 00000000
R I 00000200 00000000 0 00000000

//--- testbench/soc_bus_tb.sv
`timescale 1ns/100ps
`default_nettype none

module soc_bus_tb;

  localparam int ready_timeout = 64;
  localparam int unmapped_wait = 8;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1

  logic        clk;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst_addr;
  logic [31:0] inst_wdata;
  logic [3:0]  inst_wstrb;
  logic [31:0] inst_rdata;
  logic        inst_ready;
  logic        data_valid;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [3:0]  data_wstrb;
  logic [31:0] data_rdata;
  logic        data_ready;
  logic        tx;
  logic        msip;
  logic        mtip;

  logic [31:0] bram_model [0:soc_pkg::bram_depth-1];
  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          last_ready_cycle;
  int          uart_last_ready;
  int          uart_writes;
  logic [7:0]  expected_bytes [$];
  logic [7:0]  captured_bytes [$];
  logic        captured_start [$];
  logic        captured_stop [$];
  logic [7:0]  rx_byte;
  logic        rx_start;
  logic        rx_stop;
  int          fd;
  int          n;
  int          step;
  logic        done;
  logic [7:0]  op_tok;
  logic [7:0]  port_tok;
  logic [31:0] addr_f;
  logic [31:0] wdata_f;
  logic [3:0]  wstrb_f;
  logic [31:0] expected_f;
  logic [8*128-1:0] line_buf;
  string       step_name;

  soc_bus soc_bus_inst (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (inst_valid),
    .inst_addr_i  (inst_addr),
    .inst_wdata_i (inst_wdata),
    .inst_wstrb_i (inst_wstrb),
    .inst_rdata_o (inst_rdata),
    .inst_ready_o (inst_ready),
    .data_valid_i (data_valid),
    .data_addr_i  (data_addr),
    .data_wdata_i (data_wdata),
    .data_wstrb_i (data_wstrb),
    .data_rdata_o (data_rdata),
    .data_ready_o (data_ready),
    .tx_o         (tx),
    .msip_o       (msip),
    .mtip_o       (mtip)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  // Start bit is first seen half a clock in, so later samples land near mid-bit
  always @(negedge clk) begin
    if (rst === 1'b1 && tx === 1'b0) begin
      repeat (soc_pkg::uart_clks_per_bit / 2) @(negedge clk);
      rx_start = tx;
      for (int i = 0; i < 8; i++) begin
        repeat (soc_pkg::uart_clks_per_bit) @(negedge clk);
        rx_byte[i] = tx; // LSB first
      end
      repeat (soc_pkg::uart_clks_per_bit) @(negedge clk);
      rx_stop = tx;
      captured_bytes.push_back(rx_byte);
      captured_start.push_back(rx_start);
      captured_stop.push_back(rx_stop);
    end
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAILED %s expected %08h actual %08h", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAILED %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected) begin
      stop_on_error($sformatf("FAILED %s expected %02h actual %02h", name, expected, actual));
    end
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
  endfunction

  task automatic random_word(output logic [31:0] word);
    word = 32'h0;
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      word = {word[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic in_bram(input logic [31:0] addr);
    return addr >= soc_pkg::bram_base_addr && addr < soc_pkg::bram_top_addr;
  endfunction

  function automatic logic [9:0] bram_index(input logic [31:0] addr);
    return 10'((addr - soc_pkg::bram_base_addr) >> 2);
  endfunction

  task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb);
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        bram_model[bram_index(addr)][8*b +: 8] = wdata[8*b +: 8];
      end
    end
  endtask

  task automatic set_request(input logic is_inst, input logic valid, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
    if (is_inst) begin
      inst_valid = valid;
      inst_addr  = addr;
      inst_wdata = wdata;
      inst_wstrb = wstrb;
    end else begin
      data_valid = valid;
      data_addr  = addr;
      data_wdata = wdata;
      data_wstrb = wstrb;
    end
  endtask

  // Returns one clock after the ready cycle, with valid already dropped
  task automatic wait_ready(input logic is_inst, output logic [31:0] rdata);
    int   cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    rdata = 32'h0;
    while (!seen && cycles < ready_timeout) begin
      @(negedge clk);
      cycles++;
      if (is_inst ? inst_ready : data_ready) begin
        seen = 1'b1;
        rdata = is_inst ? inst_rdata : data_rdata;
        last_ready_cycle = cycle_count;
      end
      @(posedge clk);
      #1;
    end
    if (!seen) begin
      stop_on_error($sformatf("no ready from port %s within %0d cycles",
                              is_inst ? "inst" : "data", ready_timeout));
    end
    set_request(is_inst, 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic bus_access(input logic is_inst, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            output logic [31:0] rdata);
    set_request(is_inst, 1'b1, addr, wdata, wstrb);
    wait_ready(is_inst, rdata);
  endtask

  task automatic fill_bram_random();
    logic [31:0] word;
    logic [31:0] addr;
    logic [31:0] rd;
    for (int i = 0; i < 4; i++) begin
      random_word(word);
      addr = soc_pkg::bram_base_addr + 32'h200 + 32'(4 * i);
      bus_access(1'b0, addr, word, 4'hf, rd);
      model_write(addr, word, 4'hf);
    end
  endtask

  // Data write and instruction read of one word in the same cycle
  task automatic collide_pair(input string name, input logic [31:0] addr,
                              input logic [31:0] wdata, input logic [3:0] wstrb);
    logic        data_done;
    logic        inst_done;
    int          cycles;
    int          data_cycle;
    int          inst_cycle;
    logic [31:0] inst_word;
    data_done = 1'b0;
    inst_done = 1'b0;
    cycles = 0;
    data_cycle = 0;
    inst_cycle = 0;
    inst_word = 32'h0;
    set_request(1'b0, 1'b1, addr, wdata, wstrb);
    set_request(1'b1, 1'b1, addr, 32'h0, 4'h0);
    model_write(addr, wdata, wstrb);
    while (!(data_done && inst_done) && cycles < ready_timeout) begin
      @(negedge clk);
      cycles++;
      if (!data_done && data_ready) begin
        data_done = 1'b1;
        data_cycle = cycle_count;
      end
      if (!inst_done && inst_ready) begin
        inst_done = 1'b1;
        inst_cycle = cycle_count;
        inst_word = inst_rdata;
      end
      @(posedge clk);
      #1;
      if (data_done) data_valid = 1'b0;
      if (inst_done) inst_valid = 1'b0;
    end
    if (!data_done || !inst_done) begin
      stop_on_error($sformatf("no ready from port %s during the collision in %s",
                              data_done ? "inst" : "data", name));
    end
    if (data_cycle >= inst_cycle) begin
      stop_on_error($sformatf("%s: the instruction port got ready before the data port", name));
    end
    check_word(name, bram_model[bram_index(addr)], inst_word);
  endtask

  task automatic uart_write(input string name, input logic is_inst, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wstrb,
                            input logic [7:0] expected);
    logic [31:0] rd;
    logic        in_flight;
    int          prev_ready;
    prev_ready = uart_last_ready;
    in_flight = (uart_writes > 0) &&
                (cycle_count < prev_ready + 10 * soc_pkg::uart_clks_per_bit);
    bus_access(is_inst, addr, wdata, wstrb, rd);
    // A frame in flight holds the next write until its stop bit
    if (in_flight && last_ready_cycle < prev_ready + 9 * soc_pkg::uart_clks_per_bit) begin
      stop_on_error($sformatf("%s: UART write accepted before the previous stop bit", name));
    end
    uart_last_ready = last_ready_cycle;
    uart_writes++;
    expected_bytes.push_back(expected);
  endtask

  task automatic timer_test(input string name, input logic is_inst, input logic [31:0] base,
                            input logic [31:0] delta, input logic expected);
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] rd;
    logic        risen;
    int          cycles;
    bus_access(is_inst, base + soc_pkg::clint_mtime_offset, 32'h0, 4'h0, t0);
    bus_access(is_inst, base + soc_pkg::clint_mtime_offset, 32'h0, 4'h0, t1);
    if (t1 <= t0) begin
      stop_on_error($sformatf("%s: mtime went from %08h to %08h", name, t0, t1));
    end
    bus_access(is_inst, base + soc_pkg::clint_mtimecmp_offset, t1 + delta, 4'hf, rd);
    bus_access(is_inst, base + soc_pkg::clint_mtimecmp_offset + 32'd4, 32'h0, 4'hf, rd);
    check_bit({name, " mtip before compare"}, 1'b0, mtip);
    risen = 1'b0;
    cycles = 0;
    while (!risen && cycles < ready_timeout) begin
      @(negedge clk);
      cycles++;
      risen = mtip;
      @(posedge clk);
      #1;
    end
    check_bit({name, " mtip rise"}, expected, risen);
    bus_access(is_inst, base + soc_pkg::clint_mtimecmp_offset, 32'hffff_ffff, 4'hf, rd);
    bus_access(is_inst, base + soc_pkg::clint_mtimecmp_offset + 32'd4, 32'hffff_ffff, 4'hf, rd);
    check_bit({name, " mtip cleared"}, 1'b0, mtip);
  endtask

  task automatic unmapped_read(input logic is_inst, input logic [31:0] addr);
    set_request(is_inst, 1'b1, addr, 32'h0, 4'h0);
    for (int i = 0; i < unmapped_wait; i++) begin
      @(negedge clk);
      if (is_inst ? inst_ready : data_ready) begin
        stop_on_error($sformatf("ready returned for unmapped address %08h", addr));
      end
      @(posedge clk);
      #1;
    end
    set_request(is_inst, 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic run_step(input string name, input logic [7:0] op, input logic is_inst,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] wstrb, input logic [31:0] expected);
    logic [31:0] rd;
    case (op)
      "W": begin
        bus_access(is_inst, addr, wdata, wstrb, rd);
        if (in_bram(addr)) model_write(addr, wdata, wstrb);
        if (addr == soc_pkg::clint_base_addr + soc_pkg::clint_msip_offset) begin
          check_bit(name, expected[0], msip);
        end
      end
      "R": begin
        bus_access(is_inst, addr, 32'h0, 4'h0, rd);
        check_word(name, in_bram(addr) ? bram_model[bram_index(addr)] : expected, rd);
      end
      "P": collide_pair(name, addr, wdata, wstrb);
      "U": uart_write(name, is_inst, addr, wdata, wstrb, expected[7:0]);
      "T": timer_test(name, is_inst, addr, wdata, expected[0]);
      "N": unmapped_read(is_inst, addr);
      default: stop_on_error($sformatf("unknown operation %c in %s", op, name));
    endcase
  endtask

  task automatic check_frames();
    int cycles;
    cycles = 0;
    while (captured_bytes.size() < expected_bytes.size() && cycles < ready_timeout) begin
      @(negedge clk);
      cycles++;
    end
    if (captured_bytes.size() != expected_bytes.size()) begin
      stop_on_error($sformatf("saw %0d UART frames on tx but %0d bytes were written",
                              captured_bytes.size(), expected_bytes.size()));
    end
    foreach (expected_bytes[i]) begin
      check_bit($sformatf("uart frame %0d start bit", i), 1'b0, captured_start[i]);
      check_byte($sformatf("uart frame %0d data", i), expected_bytes[i], captured_bytes[i]);
      check_bit($sformatf("uart frame %0d stop bit", i), 1'b1, captured_stop[i]);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b0;
    lfsr_state = 32'h1011;
    last_ready_cycle = 0;
    uart_last_ready = 0;
    uart_writes = 0;
    set_request(1'b1, 1'b0, 32'h0, 32'h0, 4'h0);
    set_request(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b1;
    fill_bram_random();
    fd = $fopen("testbench/soc_bus_stimulus.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open testbench/soc_bus_stimulus.txt");
    end
    step = 0;
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", op_tok);
      if (n != 1) begin
        done = 1'b1;
      end else if (op_tok == "#") begin
        n = $fgets(line_buf, fd); // Rest of a comment line
      end else begin
        n = $fscanf(fd, "%s %h %h %h %h", port_tok, addr_f, wdata_f, wstrb_f, expected_f);
        step++;
        if (n != 5) begin
          stop_on_error($sformatf("stimulus line %0d is missing fields", step));
        end
        step_name = $sformatf("step %0d %c", step, op_tok);
        run_step(step_name, op_tok, port_tok == "I", addr_f, wdata_f, wstrb_f, expected_f);
      end
    end
    $fclose(fd);
    check_frames();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- uart/uart.sv
`timescale 1ns/100ps
`default_nettype none

module uart (
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        valid_i,
  input  wire logic [31:0] addr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  wstrb_i,
  output logic      [31:0] rdata_o,
  output logic             ready_o,
  output logic             tx_o
);

  logic [9:0] shift_r; // Frame from stop bit down to start bit with bit 0 driving the line
  logic [3:0] bit_cnt_r;
  logic [7:0] clk_cnt_r;
  logic       busy_r;
  logic       access;
  logic       data_write;
  logic       bit_end;

  assign access     = valid_i && !ready_o;
  assign data_write = (addr_i == soc_pkg::uart_data_offset) && (wstrb_i != 4'b0000);
  assign bit_end    = (clk_cnt_r == 8'(soc_pkg::uart_clks_per_bit - 1));
  assign tx_o       = shift_r[0];

  always_ff @(posedge clk) begin
    if (!rst) begin
      shift_r   <= '1;
      bit_cnt_r <= 4'd0;
      clk_cnt_r <= 8'd0;
      busy_r    <= 1'b0;
      ready_o   <= 1'b0;
    end else begin
      ready_o <= 1'b0;
      if (busy_r) begin
        if (bit_end) begin
          clk_cnt_r <= 8'd0;
          if (bit_cnt_r == 4'd9) begin
            busy_r <= 1'b0; // The line stays high after the stop bit
          end else begin
            bit_cnt_r <= bit_cnt_r + 4'd1;
            shift_r   <= {1'b1, shift_r[9:1]};
          end
        end else begin
          clk_cnt_r <= clk_cnt_r + 8'd1;
        end
      end
      if (access) begin
        if (!data_write) begin
          ready_o <= 1'b1;
        end else if (!busy_r) begin
          shift_r   <= {1'b1, wdata_i[7:0], 1'b0};
          bit_cnt_r <= 4'd0;
          clk_cnt_r <= 8'd0;
          busy_r    <= 1'b1;
          ready_o   <= 1'b1;
        end
        // A data write while busy waits here until the frame ends
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (addr_i == soc_pkg::uart_status_offset) begin
        rdata_o <= {31'h0, busy_r};
      end else begin
        rdata_o <= 32'h0;
      end
    end
  end

endmodule

`default_nettype wire
